// ==== bench/wordGameTb.sv ====
/* Testbench for the word game core.
   Plays a table of games through the host and guess channels and checks every scored
   guess against a reference model of the game rules. */
`timescale 1ns/1ns
`include "wordGame_cfg.svh"

module wordGameTb;
    import wordGamePkg::*;

    localparam int NUM_GAMES = 4;
    localparam word_t BLANK_WORD = {`WORD_LEN{`BLANK_CHAR}};

    logic    clk = 1'b0;
    logic    nRst;
    letter_t hostLetter;
    logic    hostValid;
    logic    hostReady;
    logic    hostConfirm;
    logic    newGame;
    letter_t guessLetter;
    logic    guessValid;
    logic    guessReady;
    word_t   revealWord;
    count_t  correctCount;
    count_t  mistakeCount;
    logic    mistakePulse;
    logic    win;
    logic    lose;

    // One game per entry. A '*' in a guess string stands for a zero guess.
    word_t tableWord[NUM_GAMES]    = '{"LEVEL", "CRANE", "GAMES", "BOOKS"};
    string tableGuesses[NUM_GAMES] = '{"EXE*LV", "AQZJKWY", "S*TM", "OBKS"};
    bit    tableNewGame[NUM_GAMES] = '{1'b0, 1'b1, 1'b1, 1'b1};

    mask_t refMask;
    int    refCorrect;
    int    refMistakes;
    bit    refPulse;
    bit    refWin;
    bit    refLose;

    int          errorCount     = 0;
    int          cycleCount     = 0;
    int          cycleLimit     = 0;
    int          acceptCount    = 0;
    int          submittedCount = 0;
    int unsigned lcgState       = 52;

    wordGame i_dut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (nRst && guessValid && guessReady) begin
            acceptCount++;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the games did not finish within %0d cycles", cycleLimit);
            $display("Errors: %0d value checks, %0d assertions, 1 timeout", errorCount,
                     i_dut.i_gameLogic.i_checker.failCount);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic int unsigned nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState >> 16;
    endfunction

    // Unrevealed positions show the blank character.
    function automatic word_t expectedDisplay(input word_t word, input mask_t mask);
        word_t shown;
        for (int i = 0; i < `WORD_LEN; i++) begin
            shown[(`WORD_LEN - 1 - i) * 8 +: 8] =
                mask[i] ? word[(`WORD_LEN - 1 - i) * 8 +: 8] : `BLANK_CHAR;
        end
        return shown;
    endfunction

    task automatic compareField(input string name, input logic [39:0] got,
                                input logic [39:0] expected);
        assert (got === expected) else begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
            errorCount++;
        end
    endtask

    task automatic startNewGame();
        @(negedge clk);
        newGame = 1'b1;
        @(negedge clk);
        newGame = 1'b0;
        @(negedge clk);
        compareField("correctCount", correctCount, 0);
        compareField("mistakeCount", mistakeCount, 0);
        compareField("win", win, 0);
        compareField("lose", lose, 0);
        compareField("guessReady", guessReady, 0);
        compareField("hostReady", hostReady, 1);
        compareField("revealWord", revealWord, BLANK_WORD);
        refMask     = '0;
        refCorrect  = 0;
        refMistakes = 0;
        refWin      = 1'b0;
        refLose     = 1'b0;
    endtask

    task automatic loadWord(input word_t word);
        int gap;
        for (int i = 0; i < `WORD_LEN; i++) begin
            gap = nextRandom() % 3;
            repeat (gap) @(negedge clk);
            @(negedge clk);
            hostValid  = 1'b1;
            hostLetter = word[(`WORD_LEN - 1 - i) * 8 +: 8];
            while (!hostReady) begin
                @(negedge clk);
            end
            @(posedge clk);
            @(negedge clk);
            hostValid  = 1'b0;
            hostLetter = 8'h00;
        end
        compareField("hostReady", hostReady, 0);
    endtask

    task automatic submitGuess(input letter_t letter, input bit confirmFirst);
        @(negedge clk);
        guessValid  = 1'b1;
        guessLetter = letter;
        // The first guess is offered before the word is confirmed, so it has to wait.
        if (confirmFirst) begin
            @(negedge clk);
            compareField("guessReady", guessReady, 0);
            hostConfirm = 1'b1;
            @(negedge clk);
            hostConfirm = 1'b0;
        end
        while (!guessReady) begin
            @(negedge clk);
        end
        @(posedge clk);
        submittedCount++;
        @(negedge clk);
        guessValid  = 1'b0;
        guessLetter = 8'h00;
    endtask

    task automatic scoreGuess(input letter_t letter, input word_t word);
        int hits;
        hits     = 0;
        refPulse = 1'b0;
        if (letter != 8'h00) begin
            for (int i = 0; i < `WORD_LEN; i++) begin
                if (word[(`WORD_LEN - 1 - i) * 8 +: 8] == letter && !refMask[i]) begin
                    refMask[i] = 1'b1;
                    hits++;
                end
            end
            if (hits > 0) begin
                refCorrect += hits;
                refWin = (refCorrect == `WORD_LEN);
            end else begin
                refMistakes++;
                refPulse = 1'b1;
                refLose  = (refMistakes == `MAX_MISTAKES);
            end
        end
    endtask

    // Counts and flags settle on the seventh edge after acceptance, the display one later.
    task automatic checkResult(input word_t word);
        repeat (6) begin
            @(negedge clk);
            compareField("guessReady", guessReady, 0);
            compareField("mistakePulse", mistakePulse, 0);
        end
        @(negedge clk);
        compareField("correctCount", correctCount, refCorrect);
        compareField("mistakeCount", mistakeCount, refMistakes);
        compareField("mistakePulse", mistakePulse, refPulse);
        compareField("win", win, refWin);
        compareField("lose", lose, refLose);
        compareField("guessReady", guessReady, !(refWin || refLose));
        @(negedge clk);
        compareField("revealWord", revealWord, expectedDisplay(word, refMask));
        compareField("mistakePulse", mistakePulse, 0);
    endtask

    task automatic playGame(input int g);
        letter_t letter;
        if (tableNewGame[g]) begin
            startNewGame();
        end
        loadWord(tableWord[g]);
        for (int k = 0; k < tableGuesses[g].len() && !(refWin || refLose); k++) begin
            letter = (tableGuesses[g][k] == "*") ? 8'h00 : tableGuesses[g][k];
            submitGuess(letter, k == 0);
            scoreGuess(letter, tableWord[g]);
            checkResult(tableWord[g]);
        end
        // A finished game keeps the guess channel closed until the next new game.
        if (refWin || refLose) begin
            repeat (3) begin
                @(negedge clk);
                compareField("guessReady", guessReady, 0);
            end
        end
    endtask

    initial begin
        nRst        = 1'b0;
        hostLetter  = 8'h00;
        hostValid   = 1'b0;
        hostConfirm = 1'b0;
        newGame     = 1'b0;
        guessLetter = 8'h00;
        guessValid  = 1'b0;
        refMask     = '0;
        refCorrect  = 0;
        refMistakes = 0;
        refPulse    = 1'b0;
        refWin      = 1'b0;
        refLose     = 1'b0;
        for (int g = 0; g < NUM_GAMES; g++) begin
            cycleLimit += 40 * tableGuesses[g].len() + 20;
        end
        repeat (10) @(negedge clk);
        nRst = 1'b1;
        @(negedge clk);
        compareField("hostReady", hostReady, 1);
        compareField("guessReady", guessReady, 0);
        compareField("revealWord", revealWord, BLANK_WORD);
        compareField("correctCount", correctCount, 0);
        compareField("mistakeCount", mistakeCount, 0);
        compareField("mistakePulse", mistakePulse, 0);
        compareField("win", win, 0);
        compareField("lose", lose, 0);
        for (int g = 0; g < NUM_GAMES; g++) begin
            playGame(g);
        end
        compareField("acceptedGuesses", acceptCount, submittedCount);
        $display("Errors: %0d value checks, %0d assertions, 0 timeouts", errorCount,
                 i_dut.i_gameLogic.i_checker.failCount);
        if (errorCount == 0 && i_dut.i_gameLogic.i_checker.failCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== bench/wordGame_checker.sv ====
/* Assertion checker bound into the game FSM.
   Watches the guess handshake, the scoring counters and the end-of-game flags. */
`timescale 1ns/1ns
`include "wordGame_cfg.svh"

module wordGame_checker (
    input logic                clk,
    input logic                nRst,
    input logic                guessReady,
    input wordGamePkg::count_t hitTally,
    input wordGamePkg::count_t mistakeCount,
    input logic                mistakePulse,
    input logic                win,
    input logic                lose
);
    int failCount = 0;

    // A guess still being scored keeps the guess channel closed.
    busyWhileScoring: assert property (@(posedge clk) disable iff (!nRst)
        !(guessReady && (hitTally != '0)))
        else begin
            $error("guessReady is high while a hit tally is pending");
            failCount++;
        end

    mistakeLimit: assert property (@(posedge clk) disable iff (!nRst)
        mistakeCount <= `MAX_MISTAKES)
        else begin
            $error("mistakeCount went past the mistake limit");
            failCount++;
        end

    singleResult: assert property (@(posedge clk) disable iff (!nRst)
        !(win && lose))
        else begin
            $error("win and lose are high together");
            failCount++;
        end

    pulseOneCycle: assert property (@(posedge clk) disable iff (!nRst)
        mistakePulse |=> !mistakePulse)
        else begin
            $error("mistakePulse stayed high for more than one cycle");
            failCount++;
        end

endmodule

bind gameLogic wordGame_checker i_checker (
    .clk          (clk),
    .nRst         (nRst),
    .guessReady   (guessReady),
    .hitTally     (hitTally),
    .mistakeCount (mistakeCount),
    .mistakePulse (mistakePulse),
    .win          (win),
    .lose         (lose)
);

// ==== design/gameLogic.sv ====
/* Game FSM for the word game.
   Accepts guesses while idle, walks the secret word one position per cycle, then updates
   the reveal mask and the correct and mistake counts and decides win or loss. */
`timescale 1ns/1ns
`include "wordGame_cfg.svh"

module gameLogic (
    input  logic                 clk,
    input  logic                 nRst,
    input  logic                 hostConfirm,
    input  logic                 newGame,
    input  wordGamePkg::word_t   secretWord,
    input  logic                 wordReady,
    output logic                 loadEnable,
    input  wordGamePkg::letter_t guessLetter,
    input  logic                 guessValid,
    output logic                 guessReady,
    output wordGamePkg::mask_t   revealMask,
    output wordGamePkg::count_t  correctCount,
    output wordGamePkg::count_t  mistakeCount,
    output logic                 mistakePulse,
    output logic                 win,
    output logic                 lose
);
    import wordGamePkg::*;

    gameState_t state;
    gameState_t nextState;

    letter_t    guessReg;
    logic [2:0] posIdx;
    logic [2:0] cmpIdx;
    logic [2:0] cmpPos;
    logic       cmpHit;
    logic       cmpMatch;
    count_t     hitTally;
    mask_t      workMask;

    count_t     sumCorrect;
    count_t     bumpMistake;
    logic       isMistake;
    logic       winNext;
    logic       loseNext;

    function automatic letter_t letterAt(word_t w, logic [2:0] pos);
        return w[(`WORD_LEN - 1 - pos) * 8 +: 8];
    endfunction

    assign loadEnable = (state == SET) && !newGame;
    assign guessReady = (state == IDLE) && !newGame;

    // Compare stage. The hit is registered and folded into the tally one cycle later.
    assign cmpIdx   = (posIdx < `WORD_LEN) ? posIdx : 3'd0;
    assign cmpMatch = (guessReg != '0) &&
                      (guessReg == letterAt(secretWord, cmpIdx)) &&
                      !workMask[cmpIdx];

    // Scoring for the STOP cycle.
    assign sumCorrect  = correctCount + hitTally;
    assign bumpMistake = mistakeCount + 3'd1;
    assign isMistake   = (hitTally == '0) && (guessReg != '0);
    assign winNext     = (hitTally != '0) && (sumCorrect == `WORD_LEN);
    assign loseNext    = isMistake && (bumpMistake == `MAX_MISTAKES);

    always_comb begin
        nextState = state;
        case (state)
            SET: begin
                if (hostConfirm && wordReady) begin
                    nextState = IDLE;
                end
            end
            IDLE: begin
                if (guessValid) begin
                    nextState = CMP;
                end
            end
            CMP: begin
                // Index past the last letter means the final hit has been folded in.
                if (posIdx == `WORD_LEN) begin
                    nextState = STOP;
                end
            end
            STOP: begin
                if (winNext || loseNext) begin
                    nextState = DONE;
                end else begin
                    nextState = IDLE;
                end
            end
            DONE: begin
                nextState = DONE;
            end
            default: begin
                nextState = SET;
            end
        endcase
        if (newGame) begin
            nextState = SET;
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state        <= SET;
            posIdx       <= '0;
            cmpPos       <= '0;
            cmpHit       <= 1'b0;
            hitTally     <= '0;
            workMask     <= '0;
            revealMask   <= '0;
            correctCount <= '0;
            mistakeCount <= '0;
            mistakePulse <= 1'b0;
            win          <= 1'b0;
            lose         <= 1'b0;
        end else begin
            state        <= nextState;
            mistakePulse <= 1'b0;
            if (newGame) begin
                cmpHit       <= 1'b0;
                hitTally     <= '0;
                workMask     <= '0;
                revealMask   <= '0;
                correctCount <= '0;
                mistakeCount <= '0;
                win          <= 1'b0;
                lose         <= 1'b0;
            end else begin
                case (state)
                    IDLE: begin
                        if (guessValid) begin
                            posIdx   <= '0;
                            cmpHit   <= 1'b0;
                            hitTally <= '0;
                            workMask <= revealMask;
                        end
                    end
                    CMP: begin
                        if (cmpHit) begin
                            workMask[cmpPos] <= 1'b1;
                            hitTally         <= hitTally + 3'd1;
                        end
                        if (posIdx < `WORD_LEN) begin
                            cmpHit <= cmpMatch;
                            cmpPos <= posIdx;
                            posIdx <= posIdx + 3'd1;
                        end else begin
                            cmpHit <= 1'b0;
                        end
                    end
                    STOP: begin
                        revealMask <= workMask;
                        hitTally   <= '0;
                        // Repeating a revealed letter finds no new hit and so counts as a mistake.
                        if (hitTally != '0) begin
                            correctCount <= sumCorrect;
                        end else if (guessReg != '0) begin
                            mistakeCount <= bumpMistake;
                            mistakePulse <= 1'b1;
                        end
                        win  <= winNext;
                        lose <= loseNext;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // The guess letter is payload and only needs capturing on acceptance.
    always_ff @(posedge clk) begin
        if (state == IDLE && guessValid && !newGame) begin
            guessReg <= guessLetter;
        end
    end

endmodule

// ==== design/revealBuilder.sv ====
/* Display word builder.
   Registers the word shown to the player, with revealed letters in place and an underscore
   at every position the mask has not yet revealed. */
`timescale 1ns/1ns
`include "wordGame_cfg.svh"

module revealBuilder (
    input  logic               clk,
    input  logic               nRst,
    input  wordGamePkg::word_t secretWord,
    input  wordGamePkg::mask_t revealMask,
    output wordGamePkg::word_t revealWord
);
    import wordGamePkg::*;

    localparam word_t BLANK_WORD = {`WORD_LEN{`BLANK_CHAR}};

    word_t shownWord;

    // Mask bit i selects the byte of position i, counted from the top.
    always_comb begin
        shownWord = BLANK_WORD;
        for (int i = 0; i < `WORD_LEN; i++) begin
            if (revealMask[i]) begin
                shownWord[(`WORD_LEN - 1 - i) * 8 +: 8] =
                    secretWord[(`WORD_LEN - 1 - i) * 8 +: 8];
            end
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            revealWord <= BLANK_WORD;
        end else begin
            revealWord <= shownWord;
        end
    end

endmodule

// ==== design/wordGame.sv ====
/* Top level of the word game core.
   Connects the secret word loader, the game FSM and the display builder to the host
   channel, the guess channel and the status outputs. */
`timescale 1ns/1ns

module wordGame (
    input  logic                 clk,
    input  logic                 nRst,
    input  wordGamePkg::letter_t hostLetter,
    input  logic                 hostValid,
    output logic                 hostReady,
    input  logic                 hostConfirm,
    input  logic                 newGame,
    input  wordGamePkg::letter_t guessLetter,
    input  logic                 guessValid,
    output logic                 guessReady,
    output wordGamePkg::word_t   revealWord,
    output wordGamePkg::count_t  correctCount,
    output wordGamePkg::count_t  mistakeCount,
    output logic                 mistakePulse,
    output logic                 win,
    output logic                 lose
);
    import wordGamePkg::*;

    word_t secretWord;
    logic  wordReady;
    logic  loadEnable;
    mask_t revealMask;

    wordLoader i_wordLoader (
        .clk        (clk),
        .nRst       (nRst),
        .hostLetter (hostLetter),
        .hostValid  (hostValid),
        .hostReady  (hostReady),
        .loadEnable (loadEnable),
        .secretWord (secretWord),
        .wordReady  (wordReady)
    );

    gameLogic i_gameLogic (
        .clk          (clk),
        .nRst         (nRst),
        .hostConfirm  (hostConfirm),
        .newGame      (newGame),
        .secretWord   (secretWord),
        .wordReady    (wordReady),
        .loadEnable   (loadEnable),
        .guessLetter  (guessLetter),
        .guessValid   (guessValid),
        .guessReady   (guessReady),
        .revealMask   (revealMask),
        .correctCount (correctCount),
        .mistakeCount (mistakeCount),
        .mistakePulse (mistakePulse),
        .win          (win),
        .lose         (lose)
    );

    revealBuilder i_revealBuilder (
        .clk        (clk),
        .nRst       (nRst),
        .secretWord (secretWord),
        .revealMask (revealMask),
        .revealWord (revealWord)
    );

endmodule

// ==== design/wordGamePkg.sv ====
/* Shared types for the word game core.
   RTL modules import this package for letters, words, masks, counters and FSM states. */
`include "wordGame_cfg.svh"

package wordGamePkg;

    // One ASCII letter. Zero means no letter.
    typedef logic [7:0] letter_t;

    // Position 0 sits in the most significant byte.
    typedef logic [`WORD_LEN*8-1:0] word_t;

    // Bit i is set once position i is revealed.
    typedef logic [`WORD_LEN-1:0] mask_t;

    typedef logic [2:0] count_t;

    // CMP walks the word with a position index.
    typedef enum logic [2:0] {
        SET,
        CMP,
        STOP,
        IDLE,
        DONE
    } gameState_t;

endpackage

// ==== design/wordGame_cfg.svh ====
/* Build-time sizes for the word game core.
   Included by the package and by every RTL file that needs the word size or game limits. */
`ifndef WORDGAME_CFG_SVH
`define WORDGAME_CFG_SVH

// Letters in the secret word.
`define WORD_LEN 5

// Mistakes that end a game as a loss.
`define MAX_MISTAKES 6

`define BLANK_CHAR 8'h5F

`endif

// ==== design/wordLoader.sv ====
/* Secret word loader.
   Takes host letters over a valid/ready channel while loading is enabled and shifts them
   into the word register, reporting when a full word is held. */
`timescale 1ns/1ns
`include "wordGame_cfg.svh"

module wordLoader (
    input  logic                clk,
    input  logic                nRst,
    input  wordGamePkg::letter_t hostLetter,
    input  logic                hostValid,
    output logic                hostReady,
    input  logic                loadEnable,
    output wordGamePkg::word_t  secretWord,
    output logic                wordReady
);
    import wordGamePkg::*;

    count_t letterCount;
    logic   accept;
    word_t  shiftedWord;

    assign hostReady = loadEnable && (letterCount < `WORD_LEN);
    assign accept    = hostValid && hostReady;
    assign wordReady = (letterCount == `WORD_LEN);

    // The first letter of a word drops whatever an earlier game left behind.
    always_comb begin
        if (letterCount == '0) begin
            shiftedWord = word_t'(hostLetter);
        end else begin
            shiftedWord = {secretWord[`WORD_LEN*8-9:0], hostLetter};
        end
    end

    // The count restarts whenever loading is disabled, so each new game starts empty.
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            letterCount <= '0;
        end else if (!loadEnable) begin
            letterCount <= '0;
        end else if (accept) begin
            letterCount <= letterCount + 3'd1;
        end
    end

    // New letters enter at the low byte and move up one byte per letter.
    always_ff @(posedge clk) begin
        if (accept) begin
            secretWord <= shiftedWord;
        end
    end

endmodule

// ==== wordGame.f ====
+incdir+design
design/wordGamePkg.sv
design/wordLoader.sv
design/gameLogic.sv
design/revealBuilder.sv
design/wordGame.sv
bench/wordGame_checker.sv
bench/wordGameTb.sv
